// File: design/pbus_gpio_in.sv
// input gpio bank with two-flop synchronizer and change interrupt
`timescale 1ns/1ps

module pbus_gpio_in #(
    parameter int unsigned GPIO_IN_WIDTH = 8
)(
    input  logic                                     pbus_clock_i,
    input  logic                                     arst_n_i,
    input  logic                                     wr_i,
    input  logic [pbus_pkg::PBUS_REG_OFFS_WIDTH-1:0] offs_i,
    input  logic [pbus_pkg::PBUS_DATA_WIDTH-1:0]     wdata_i,
    output logic [pbus_pkg::PBUS_DATA_WIDTH-1:0]     rdata_o,
    input  logic [GPIO_IN_WIDTH-1:0]                 gpio_in_i,
    output logic                                     irq_o
);

    logic [GPIO_IN_WIDTH-1:0] sync1_q, sync2_q;  // sync2_q is DATA
    logic [GPIO_IN_WIDTH-1:0] prev_q;            // last synchronized value
    logic                     status_q, enable_q;
    logic                     changed;

    assign changed = (sync2_q != prev_q);

    //////////////////////////////
    // synchronizer and edge detect
    //////////////////////////////
    always_ff @(posedge pbus_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync1_q <= '0;
            sync2_q <= '0;
            prev_q  <= '0;  // no false change after reset
        end else begin
            sync1_q <= gpio_in_i;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
        end
    end

    //////////////////////////////
    // irq registers
    //////////////////////////////
    always_ff @(posedge pbus_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            status_q <= 1'b0;
            enable_q <= 1'b0;
        end else begin
            // a new change beats a clear in the same cycle
            if (changed)
                status_q <= 1'b1;
            else if (wr_i && offs_i == pbus_pkg::GPIO_IRQ_STATUS_OFFS && wdata_i[0])
                status_q <= 1'b0;
            if (wr_i && offs_i == pbus_pkg::GPIO_IRQ_ENABLE_OFFS)
                enable_q <= wdata_i[0];
        end
    end

    always_comb begin
        rdata_o = '0;
        case (offs_i)
            pbus_pkg::GPIO_DATA_OFFS:       rdata_o[GPIO_IN_WIDTH-1:0] = sync2_q;
            pbus_pkg::GPIO_IRQ_STATUS_OFFS: rdata_o[0] = status_q;
            pbus_pkg::GPIO_IRQ_ENABLE_OFFS: rdata_o[0] = enable_q;
            default:                        rdata_o = '0;
        endcase
    end

    assign irq_o = status_q & enable_q;

endmodule : pbus_gpio_in

// File: design/pbus_gpio_out.sv
// output gpio bank, one data register driving the pins
`timescale 1ns/1ps

module pbus_gpio_out #(
    parameter int unsigned GPIO_OUT_WIDTH = 8
)(
    input  logic                                     pbus_clock_i,
    input  logic                                     arst_n_i,
    input  logic                                     wr_i,
    input  logic [pbus_pkg::PBUS_REG_OFFS_WIDTH-1:0] offs_i,
    input  logic [pbus_pkg::PBUS_DATA_WIDTH-1:0]     wdata_i,
    output logic [pbus_pkg::PBUS_DATA_WIDTH-1:0]     rdata_o,
    output logic [GPIO_OUT_WIDTH-1:0]                gpio_out_o
);

    logic [GPIO_OUT_WIDTH-1:0] data_q;
    logic                      data_hit;

    assign data_hit = (offs_i == pbus_pkg::GPIO_DATA_OFFS);

    always_ff @(posedge pbus_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            data_q <= '0;  // pins low out of reset
        end else if (wr_i && data_hit) begin
            data_q <= wdata_i[GPIO_OUT_WIDTH-1:0];  // upper bits dropped
        end
    end

    always_comb begin
        rdata_o = '0;
        if (data_hit) rdata_o[GPIO_OUT_WIDTH-1:0] = data_q;  // zero-extended
    end

    assign gpio_out_o = data_q;

endmodule : pbus_gpio_out

// File: design/pbus_pkg.sv
// peripheral bus shared widths, memory map, register offsets and encodings
package pbus_pkg;

    //////////////////////////////
    // bus widths
    //////////////////////////////
    localparam int unsigned PBUS_DATA_WIDTH     = 32;  // one word
    localparam int unsigned PBUS_ADDR_WIDTH     = 32;
    localparam int unsigned PBUS_REG_OFFS_WIDTH = 4;   // byte offset inside a window
    localparam int unsigned PBUS_WINDOW_BITS    = 12;  // 4 KiB per peripheral

    //////////////////////////////
    // interrupt vector
    //////////////////////////////
    localparam int unsigned PBUS_NUM_IRQ    = 4;
    localparam int unsigned PBUS_GPIOIN_IRQ = 0;
    localparam int unsigned PBUS_TIM0_IRQ   = 1;
    localparam int unsigned PBUS_TIM1_IRQ   = 2;
    // bit 3 reserved, tied low

    //////////////////////////////
    // memory map
    //////////////////////////////
    localparam logic [PBUS_ADDR_WIDTH-1:0] PBUS_GPIO_OUT_BASE = 32'h0000_0000;
    localparam logic [PBUS_ADDR_WIDTH-1:0] PBUS_GPIO_IN_BASE  = 32'h0000_1000;
    localparam logic [PBUS_ADDR_WIDTH-1:0] PBUS_TIM0_BASE     = 32'h0000_2000;
    localparam logic [PBUS_ADDR_WIDTH-1:0] PBUS_TIM1_BASE     = 32'h0000_3000;

    // register offsets
    localparam logic [PBUS_REG_OFFS_WIDTH-1:0] GPIO_DATA_OFFS       = 4'h0;
    localparam logic [PBUS_REG_OFFS_WIDTH-1:0] GPIO_IRQ_STATUS_OFFS = 4'h4;  // w1c
    localparam logic [PBUS_REG_OFFS_WIDTH-1:0] GPIO_IRQ_ENABLE_OFFS = 4'h8;
    localparam logic [PBUS_REG_OFFS_WIDTH-1:0] TIM_CTRL_OFFS        = 4'h0;
    localparam logic [PBUS_REG_OFFS_WIDTH-1:0] TIM_LOAD_OFFS        = 4'h4;
    localparam logic [PBUS_REG_OFFS_WIDTH-1:0] TIM_COUNT_OFFS       = 4'h8;  // read only
    localparam logic [PBUS_REG_OFFS_WIDTH-1:0] TIM_STATUS_OFFS      = 4'hC;  // w1c

    // timer ctrl fields
    localparam int unsigned TIM_CTRL_EN_BIT     = 0;
    localparam int unsigned TIM_CTRL_RELOAD_BIT = 1;
    localparam int unsigned TIM_CTRL_IRQ_EN_BIT = 2;

    //////////////////////////////
    // enums
    //////////////////////////////
    typedef enum logic [2:0] {
        SLV_GPIO_OUT,
        SLV_GPIO_IN,
        SLV_TIM0,
        SLV_TIM1,
        SLV_NONE     // unmapped, no strobe
    } pbus_slave_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_SLVERR = 2'd2,
        RESP_DECERR = 2'd3
    } pbus_resp_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BRESP,  // holding write response
        ST_RRESP   // holding read response
    } pbus_xbar_state_e;

endpackage : pbus_pkg

// File: design/pbus_timer.sv
// down-counting timer with load, optional auto-reload and expiry interrupt
`timescale 1ns/1ps

module pbus_timer #(
    parameter int unsigned TIMER_WIDTH = 16
)(
    input  logic                                     pbus_clock_i,
    input  logic                                     arst_n_i,
    input  logic                                     wr_i,
    input  logic [pbus_pkg::PBUS_REG_OFFS_WIDTH-1:0] offs_i,
    input  logic [pbus_pkg::PBUS_DATA_WIDTH-1:0]     wdata_i,
    output logic [pbus_pkg::PBUS_DATA_WIDTH-1:0]     rdata_o,
    output logic                                     irq_o
);

    logic                   en_q, reload_q, irq_en_q;  // CTRL fields
    logic [TIMER_WIDTH-1:0] load_q, count_q;
    logic                   expired_q;
    logic                   expire;                     // enabled and at zero
    logic                   wr_ctrl, wr_load, wr_status;

    assign expire    = en_q && (count_q == '0);
    assign wr_ctrl   = wr_i && (offs_i == pbus_pkg::TIM_CTRL_OFFS);
    assign wr_load   = wr_i && (offs_i == pbus_pkg::TIM_LOAD_OFFS);
    assign wr_status = wr_i && (offs_i == pbus_pkg::TIM_STATUS_OFFS);

    //////////////////////////////
    // control and counter
    //////////////////////////////
    always_ff @(posedge pbus_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            en_q      <= 1'b0;
            reload_q  <= 1'b0;
            irq_en_q  <= 1'b0;
            load_q    <= '0;
            count_q   <= '0;
            expired_q <= 1'b0;
        end else begin
            if (wr_ctrl) begin
                en_q     <= wdata_i[pbus_pkg::TIM_CTRL_EN_BIT];
                reload_q <= wdata_i[pbus_pkg::TIM_CTRL_RELOAD_BIT];
                irq_en_q <= wdata_i[pbus_pkg::TIM_CTRL_IRQ_EN_BIT];
            end else if (expire && !reload_q) begin
                en_q <= 1'b0;  // one-shot stops itself
            end

            if (wr_load) begin
                load_q  <= wdata_i[TIMER_WIDTH-1:0];
                count_q <= wdata_i[TIMER_WIDTH-1:0];  // load also restarts count
            end else if (expire) begin
                if (reload_q) count_q <= load_q;
            end else if (en_q) begin
                count_q <= count_q - 1'b1;
            end

            // expiry wins over a simultaneous clear
            if (expire)
                expired_q <= 1'b1;
            else if (wr_status && wdata_i[0])
                expired_q <= 1'b0;
        end
    end

    //////////////////////////////
    // readback
    //////////////////////////////
    always_comb begin
        rdata_o = '0;
        case (offs_i)
            pbus_pkg::TIM_CTRL_OFFS: begin
                rdata_o[pbus_pkg::TIM_CTRL_EN_BIT]     = en_q;
                rdata_o[pbus_pkg::TIM_CTRL_RELOAD_BIT] = reload_q;
                rdata_o[pbus_pkg::TIM_CTRL_IRQ_EN_BIT] = irq_en_q;
            end
            pbus_pkg::TIM_LOAD_OFFS:   rdata_o[TIMER_WIDTH-1:0] = load_q;
            pbus_pkg::TIM_COUNT_OFFS:  rdata_o[TIMER_WIDTH-1:0] = count_q;
            pbus_pkg::TIM_STATUS_OFFS: rdata_o[0] = expired_q;
            default:                   rdata_o = '0;
        endcase
    end

    assign irq_o = expired_q & irq_en_q;  // level until status cleared

endmodule : pbus_timer

// File: design/pbus_xbar.sv
// axi-lite slave front end, decodes each access into one peripheral register strobe
`timescale 1ns/1ps

module pbus_xbar (
    input  logic                                     pbus_clock_i,
    input  logic                                     arst_n_i,
    // axi-lite slave
    input  logic [pbus_pkg::PBUS_ADDR_WIDTH-1:0]     s_awaddr_i,
    input  logic                                     s_awvalid_i,
    output logic                                     s_awready_o,
    input  logic [pbus_pkg::PBUS_DATA_WIDTH-1:0]     s_wdata_i,
    input  logic                                     s_wvalid_i,
    output logic                                     s_wready_o,
    output logic [1:0]                               s_bresp_o,
    output logic                                     s_bvalid_o,
    input  logic                                     s_bready_i,
    input  logic [pbus_pkg::PBUS_ADDR_WIDTH-1:0]     s_araddr_i,
    input  logic                                     s_arvalid_i,
    output logic                                     s_arready_o,
    output logic [pbus_pkg::PBUS_DATA_WIDTH-1:0]     s_rdata_o,
    output logic [1:0]                               s_rresp_o,
    output logic                                     s_rvalid_o,
    input  logic                                     s_rready_i,
    // register side
    output logic [pbus_pkg::PBUS_REG_OFFS_WIDTH-1:0] reg_offs_o,
    output logic [pbus_pkg::PBUS_DATA_WIDTH-1:0]     reg_wdata_o,
    output logic                                     gpio_out_wr_o,
    output logic                                     gpio_in_wr_o,
    output logic                                     tim0_wr_o,
    output logic                                     tim1_wr_o,
    input  logic [pbus_pkg::PBUS_DATA_WIDTH-1:0]     gpio_out_rdata_i,
    input  logic [pbus_pkg::PBUS_DATA_WIDTH-1:0]     gpio_in_rdata_i,
    input  logic [pbus_pkg::PBUS_DATA_WIDTH-1:0]     tim0_rdata_i,
    input  logic [pbus_pkg::PBUS_DATA_WIDTH-1:0]     tim1_rdata_i
);

    localparam int unsigned AW = pbus_pkg::PBUS_ADDR_WIDTH;
    localparam int unsigned WB = pbus_pkg::PBUS_WINDOW_BITS;

    pbus_pkg::pbus_xbar_state_e           state_q, state_d;
    pbus_pkg::pbus_slave_e                wr_slv, rd_slv;
    pbus_pkg::pbus_resp_e                 bresp_q, rresp_q;
    logic                                 wr_acc, rd_acc;
    logic [pbus_pkg::PBUS_DATA_WIDTH-1:0] rd_word, rdata_q;

    // window compare on the bits above the 4 KiB window
    function automatic pbus_pkg::pbus_slave_e decode_slave(input logic [AW-1:0] addr);
        logic [AW-1:WB] win;
        win = addr[AW-1:WB];
        if (win == pbus_pkg::PBUS_GPIO_OUT_BASE[AW-1:WB]) return pbus_pkg::SLV_GPIO_OUT;
        if (win == pbus_pkg::PBUS_GPIO_IN_BASE[AW-1:WB])  return pbus_pkg::SLV_GPIO_IN;
        if (win == pbus_pkg::PBUS_TIM0_BASE[AW-1:WB])     return pbus_pkg::SLV_TIM0;
        if (win == pbus_pkg::PBUS_TIM1_BASE[AW-1:WB])     return pbus_pkg::SLV_TIM1;
        return pbus_pkg::SLV_NONE;  // 0x4000 and above
    endfunction

    //////////////////////////////
    // handshake and strobes
    //////////////////////////////
    // write wins when aw and w arrive together
    assign wr_acc = (state_q == pbus_pkg::ST_IDLE) && s_awvalid_i && s_wvalid_i;
    assign rd_acc = (state_q == pbus_pkg::ST_IDLE) && s_arvalid_i && !(s_awvalid_i && s_wvalid_i);

    assign s_awready_o = wr_acc;
    assign s_wready_o  = wr_acc;  // aw and w taken in the same cycle
    assign s_arready_o = rd_acc;

    assign wr_slv = decode_slave(s_awaddr_i);
    assign rd_slv = decode_slave(s_araddr_i);

    assign reg_offs_o  = wr_acc ? s_awaddr_i[pbus_pkg::PBUS_REG_OFFS_WIDTH-1:0]
                                : s_araddr_i[pbus_pkg::PBUS_REG_OFFS_WIDTH-1:0];
    assign reg_wdata_o = s_wdata_i;

    assign gpio_out_wr_o = wr_acc && (wr_slv == pbus_pkg::SLV_GPIO_OUT);  // one pulse per accept
    assign gpio_in_wr_o  = wr_acc && (wr_slv == pbus_pkg::SLV_GPIO_IN);
    assign tim0_wr_o     = wr_acc && (wr_slv == pbus_pkg::SLV_TIM0);
    assign tim1_wr_o     = wr_acc && (wr_slv == pbus_pkg::SLV_TIM1);

    // read word select, peripherals answer combinationally
    always_comb begin
        case (rd_slv)
            pbus_pkg::SLV_GPIO_OUT: rd_word = gpio_out_rdata_i;
            pbus_pkg::SLV_GPIO_IN:  rd_word = gpio_in_rdata_i;
            pbus_pkg::SLV_TIM0:     rd_word = tim0_rdata_i;
            pbus_pkg::SLV_TIM1:     rd_word = tim1_rdata_i;
            default:                rd_word = '0;  // decerr reads zero
        endcase
    end

    //////////////////////////////
    // fsm
    //////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            pbus_pkg::ST_IDLE: begin
                if (wr_acc)      state_d = pbus_pkg::ST_BRESP;
                else if (rd_acc) state_d = pbus_pkg::ST_RRESP;
            end
            pbus_pkg::ST_BRESP: if (s_bready_i) state_d = pbus_pkg::ST_IDLE;
            pbus_pkg::ST_RRESP: if (s_rready_i) state_d = pbus_pkg::ST_IDLE;
            default:            state_d = pbus_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge pbus_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) state_q <= pbus_pkg::ST_IDLE;
        else           state_q <= state_d;
    end

    // response payload, captured on accept and held under back-pressure
    always_ff @(posedge pbus_clock_i) begin
        if (wr_acc) begin
            bresp_q <= (wr_slv == pbus_pkg::SLV_NONE) ? pbus_pkg::RESP_DECERR
                                                      : pbus_pkg::RESP_OKAY;
        end
        if (rd_acc) begin
            rresp_q <= (rd_slv == pbus_pkg::SLV_NONE) ? pbus_pkg::RESP_DECERR
                                                      : pbus_pkg::RESP_OKAY;
            rdata_q <= rd_word;
        end
    end

    assign s_bvalid_o = (state_q == pbus_pkg::ST_BRESP);  // one cycle after accept
    assign s_rvalid_o = (state_q == pbus_pkg::ST_RRESP);
    assign s_bresp_o  = bresp_q;
    assign s_rresp_o  = rresp_q;
    assign s_rdata_o  = rdata_q;

endmodule : pbus_xbar

// File: design/peripheral_bus.sv
// peripheral bus top, crossbar plus gpio and timer peripherals with irq vector
`timescale 1ns/1ps

module peripheral_bus #(
    parameter int unsigned GPIO_OUT_WIDTH = 8,
    parameter int unsigned GPIO_IN_WIDTH  = 8,
    parameter int unsigned TIMER_WIDTH    = 16
)(
    input  logic                                 pbus_clock_i,
    input  logic                                 arst_n_i,
    // axi-lite slave from the main interconnect
    input  logic [pbus_pkg::PBUS_ADDR_WIDTH-1:0] s_awaddr_i,
    input  logic                                 s_awvalid_i,
    output logic                                 s_awready_o,
    input  logic [pbus_pkg::PBUS_DATA_WIDTH-1:0] s_wdata_i,
    input  logic                                 s_wvalid_i,
    output logic                                 s_wready_o,
    output logic [1:0]                           s_bresp_o,
    output logic                                 s_bvalid_o,
    input  logic                                 s_bready_i,
    input  logic [pbus_pkg::PBUS_ADDR_WIDTH-1:0] s_araddr_i,
    input  logic                                 s_arvalid_i,
    output logic                                 s_arready_o,
    output logic [pbus_pkg::PBUS_DATA_WIDTH-1:0] s_rdata_o,
    output logic [1:0]                           s_rresp_o,
    output logic                                 s_rvalid_o,
    input  logic                                 s_rready_i,
    // pins
    input  logic [GPIO_IN_WIDTH-1:0]             gpio_in_i,
    output logic [GPIO_OUT_WIDTH-1:0]            gpio_out_o,
    output logic [pbus_pkg::PBUS_NUM_IRQ-1:0]    int_o
);

    logic [pbus_pkg::PBUS_REG_OFFS_WIDTH-1:0] reg_offs;
    logic [pbus_pkg::PBUS_DATA_WIDTH-1:0]     reg_wdata;
    logic gpio_out_wr, gpio_in_wr, tim0_wr, tim1_wr;
    logic [pbus_pkg::PBUS_DATA_WIDTH-1:0]     gpio_out_rdata, gpio_in_rdata;
    logic [pbus_pkg::PBUS_DATA_WIDTH-1:0]     tim0_rdata, tim1_rdata;
    logic gpio_in_int, tim0_int, tim1_int;

    //////////////////////////////
    // crossbar
    //////////////////////////////
    pbus_xbar xbar_u (
        .pbus_clock_i, .arst_n_i,
        .s_awaddr_i, .s_awvalid_i, .s_awready_o,
        .s_wdata_i, .s_wvalid_i, .s_wready_o,
        .s_bresp_o, .s_bvalid_o, .s_bready_i,
        .s_araddr_i, .s_arvalid_i, .s_arready_o,
        .s_rdata_o, .s_rresp_o, .s_rvalid_o, .s_rready_i,
        .reg_offs_o       ( reg_offs       ),
        .reg_wdata_o      ( reg_wdata      ),
        .gpio_out_wr_o    ( gpio_out_wr    ),
        .gpio_in_wr_o     ( gpio_in_wr     ),
        .tim0_wr_o        ( tim0_wr        ),
        .tim1_wr_o        ( tim1_wr        ),
        .gpio_out_rdata_i ( gpio_out_rdata ),
        .gpio_in_rdata_i  ( gpio_in_rdata  ),
        .tim0_rdata_i     ( tim0_rdata     ),
        .tim1_rdata_i     ( tim1_rdata     )
    );

    //////////////////////////////
    // peripherals
    //////////////////////////////
    pbus_gpio_out #(.GPIO_OUT_WIDTH(GPIO_OUT_WIDTH)) gpio_out_u (
        .pbus_clock_i, .arst_n_i,
        .wr_i (gpio_out_wr), .offs_i (reg_offs), .wdata_i (reg_wdata),
        .rdata_o (gpio_out_rdata), .gpio_out_o
    );

    pbus_gpio_in #(.GPIO_IN_WIDTH(GPIO_IN_WIDTH)) gpio_in_u (
        .pbus_clock_i, .arst_n_i,
        .wr_i (gpio_in_wr), .offs_i (reg_offs), .wdata_i (reg_wdata),
        .rdata_o (gpio_in_rdata), .gpio_in_i, .irq_o (gpio_in_int)
    );

    pbus_timer #(.TIMER_WIDTH(TIMER_WIDTH)) tim0_u (
        .pbus_clock_i, .arst_n_i,
        .wr_i (tim0_wr), .offs_i (reg_offs), .wdata_i (reg_wdata),
        .rdata_o (tim0_rdata), .irq_o (tim0_int)
    );

    pbus_timer #(.TIMER_WIDTH(TIMER_WIDTH)) tim1_u (
        .pbus_clock_i, .arst_n_i,
        .wr_i (tim1_wr), .offs_i (reg_offs), .wdata_i (reg_wdata),
        .rdata_o (tim1_rdata), .irq_o (tim1_int)
    );

    // interrupt vector, fixed positions
    assign int_o[pbus_pkg::PBUS_GPIOIN_IRQ]  = gpio_in_int;
    assign int_o[pbus_pkg::PBUS_TIM0_IRQ]    = tim0_int;
    assign int_o[pbus_pkg::PBUS_TIM1_IRQ]    = tim1_int;
    assign int_o[pbus_pkg::PBUS_NUM_IRQ-1]   = 1'b0;  // reserved, former uart slot

endmodule : peripheral_bus

// File: run.sh
#!/bin/sh
set -e
set -o pipefail 2>/dev/null || true
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wall -Wno-fatal --top-module tb_peripheral_bus \
    -f sim.f -o tb_sim
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
if grep -q "\*\* FAIL \*\*" sim.log; then
    exit 1
fi
grep -q "\*\* PASS \*\*" sim.log

// File: sim.f
design/pbus_pkg.sv
design/pbus_xbar.sv
design/pbus_gpio_out.sv
design/pbus_gpio_in.sv
design/pbus_timer.sv
design/peripheral_bus.sv
tests/peripheral_bus_props.sv
tests/tb_peripheral_bus.sv

// File: tests/peripheral_bus_props.sv
// bound protocol and reset properties for the peripheral bus
`timescale 1ns/1ps

module peripheral_bus_props #(
    parameter int unsigned GPIO_OUT_WIDTH = 8
)(
    input logic                      pbus_clock_i,
    input logic                      arst_n_i,
    input logic                      s_awvalid_i,
    input logic                      s_awready_o,
    input logic                      s_bvalid_o,
    input logic                      s_bready_i,
    input logic [1:0]                s_bresp_o,
    input logic                      s_arvalid_i,
    input logic                      s_arready_o,
    input logic                      s_rvalid_o,
    input logic                      s_rready_i,
    input logic [1:0]                s_rresp_o,
    input logic [31:0]               s_rdata_o,
    input logic [GPIO_OUT_WIDTH-1:0] gpio_out_o,
    input logic [3:0]                int_o
);

    ////////////////////////////////
    // back-pressure holds response
    ////////////////////////////////
    bresp_hold_a : assert property (@(posedge pbus_clock_i) disable iff (!arst_n_i)
        s_bvalid_o && !s_bready_i |=> s_bvalid_o && $stable(s_bresp_o))
        else $error("write response changed under back-pressure");

    rresp_hold_a : assert property (@(posedge pbus_clock_i) disable iff (!arst_n_i)
        s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rresp_o) && $stable(s_rdata_o))
        else $error("read response changed under back-pressure");

    // response one cycle after accept
    wr_latency_a : assert property (@(posedge pbus_clock_i) disable iff (!arst_n_i)
        s_awvalid_i && s_awready_o |=> s_bvalid_o)
        else $error("write response not one cycle after accept");

    rd_latency_a : assert property (@(posedge pbus_clock_i) disable iff (!arst_n_i)
        s_arvalid_i && s_arready_o |=> s_rvalid_o)
        else $error("read response not one cycle after accept");

    irq_rsvd_a : assert property (@(posedge pbus_clock_i) int_o[3] == 1'b0)
        else $error("reserved interrupt bit set");

    reset_out_a : assert property (@(posedge pbus_clock_i)
        !arst_n_i |-> !s_bvalid_o && !s_rvalid_o && gpio_out_o == '0 && int_o == '0)
        else $error("outputs not zero during reset");

endmodule : peripheral_bus_props

bind peripheral_bus peripheral_bus_props #(.GPIO_OUT_WIDTH(GPIO_OUT_WIDTH)) props_u (
    .pbus_clock_i (pbus_clock_i), .arst_n_i    (arst_n_i),
    .s_awvalid_i  (s_awvalid_i),  .s_awready_o (s_awready_o),
    .s_bvalid_o   (s_bvalid_o),   .s_bready_i  (s_bready_i),  .s_bresp_o (s_bresp_o),
    .s_arvalid_i  (s_arvalid_i),  .s_arready_o (s_arready_o),
    .s_rvalid_o   (s_rvalid_o),   .s_rready_i  (s_rready_i),  .s_rresp_o (s_rresp_o),
    .s_rdata_o    (s_rdata_o),    .gpio_out_o  (gpio_out_o),  .int_o     (int_o)
);

// File: tests/tb_peripheral_bus.sv
// testbench for the peripheral bus driving axi-lite accesses and checking registers and irqs
`timescale 1ns/1ps

module tb_peripheral_bus;

    logic        clk, arst_n;
    logic [31:0] s_awaddr, s_wdata, s_araddr, s_rdata;
    logic        s_awvalid, s_awready, s_wvalid, s_wready;
    logic [1:0]  s_bresp, s_rresp;
    logic        s_bvalid, s_bready, s_arvalid, s_arready, s_rvalid, s_rready;
    logic [7:0]  gpio_in, gpio_out;
    logic [3:0]  int_vec;
    integer      seed = 22653;
    int          errors = 0;
    int          cycles = 0;
    logic [31:0] rd_val, wr_val;
    logic [1:0]  resp;
    bit          seen;

    peripheral_bus peripheral_bus_inst (
        .pbus_clock_i (clk),       .arst_n_i    (arst_n),
        .s_awaddr_i   (s_awaddr),  .s_awvalid_i (s_awvalid), .s_awready_o (s_awready),
        .s_wdata_i    (s_wdata),   .s_wvalid_i  (s_wvalid),  .s_wready_o  (s_wready),
        .s_bresp_o    (s_bresp),   .s_bvalid_o  (s_bvalid),  .s_bready_i  (s_bready),
        .s_araddr_i   (s_araddr),  .s_arvalid_i (s_arvalid), .s_arready_o (s_arready),
        .s_rdata_o    (s_rdata),   .s_rresp_o   (s_rresp),   .s_rvalid_o  (s_rvalid),
        .s_rready_i   (s_rready),
        .gpio_in_i    (gpio_in),   .gpio_out_o  (gpio_out),  .int_o       (int_vec)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    // cycle limit for the whole run
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 3000) begin
            $display("timeout: the run did not finish within 3000 cycles");
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp)
        else begin
            $display("Fail at %0t: %s expected %0h got %0h", $time, name, exp, got);
            errors++;
        end
    endtask

    ////////////////////////////////
    // bus tasks
    ////////////////////////////////
    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             input int hold, output logic [1:0] bresp);
        @(negedge clk);
        s_awaddr  = addr;
        s_wdata   = data;
        s_awvalid = 1'b1;
        s_wvalid  = 1'b1;
        #1;
        while (!(s_awready && s_wready)) begin  // ready is combinational
            @(negedge clk);
            #1;
        end
        @(posedge clk);  // accept edge
        @(negedge clk);
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        while (!s_bvalid) @(negedge clk);
        repeat (hold) @(negedge clk);  // back-pressure
        bresp    = s_bresp;
        s_bready = 1'b1;
        @(negedge clk);
        s_bready = 1'b0;
    endtask

    task automatic axi_read(input logic [31:0] addr, input int hold,
                            output logic [31:0] data, output logic [1:0] rresp);
        @(negedge clk);
        s_araddr  = addr;
        s_arvalid = 1'b1;
        #1;
        while (!s_arready) begin
            @(negedge clk);
            #1;
        end
        @(posedge clk);
        @(negedge clk);
        s_arvalid = 1'b0;
        while (!s_rvalid) @(negedge clk);
        repeat (hold) @(negedge clk);
        data     = s_rdata;
        rresp    = s_rresp;
        s_rready = 1'b1;
        @(negedge clk);
        s_rready = 1'b0;
    endtask

    ////////////////////////////////
    // stimulus
    ////////////////////////////////
    initial begin
        arst_n    = 1'b0;
        s_awaddr  = '0;
        s_awvalid = 1'b0;
        s_wdata   = '0;
        s_wvalid  = 1'b0;
        s_bready  = 1'b0;
        s_araddr  = '0;
        s_arvalid = 1'b0;
        s_rready  = 1'b0;
        gpio_in   = '0;
        repeat (4) @(negedge clk);
        arst_n = 1'b1;  // released on a falling edge
        @(negedge clk);
        check_val("s_bvalid_o", 0, s_bvalid);
        check_val("s_rvalid_o", 0, s_rvalid);
        check_val("gpio_out_o", 0, gpio_out);
        check_val("int_o", 0, int_vec);

        // gpio out with random words where only the low byte reaches the pins
        for (int i = 0; i < 8; i++) begin
            wr_val = $random(seed);
            axi_write(32'h0000, wr_val, (i == 3) ? 5 : 0, resp);
            check_val("s_bresp_o", 0, resp);
            check_val("gpio_out_o", {24'h0, wr_val[7:0]}, {24'h0, gpio_out});
            axi_read(32'h0000, (i == 5) ? 5 : 0, rd_val, resp);
            check_val("s_rresp_o", 0, resp);
            check_val("s_rdata_o", {24'h0, wr_val[7:0]}, rd_val);
        end

        // gpio in sampled through two flops
        @(negedge clk);
        gpio_in = 8'($random(seed));
        repeat (4) @(negedge clk);
        axi_read(32'h1000, 0, rd_val, resp);
        check_val("s_rdata_o", {24'h0, gpio_in}, rd_val);
        axi_write(32'h1004, 32'h1, 0, resp);  // drop status from the earlier change
        axi_write(32'h1008, 32'h1, 0, resp);
        check_val("int_o[0]", 0, int_vec[0]);
        gpio_in = gpio_in ^ 8'h01;
        repeat (4) @(negedge clk);
        check_val("int_o[0]", 1, int_vec[0]);
        axi_write(32'h1004, 32'h1, 5, resp);
        check_val("int_o[0]", 0, int_vec[0]);

        // timer 0 one-shot with load 20 and irq enable
        axi_write(32'h2004, 32'd20, 0, resp);
        axi_write(32'h2000, 32'h5, 0, resp);
        seen = 1'b0;
        for (int i = 0; i < 40 && !seen; i++) begin
            @(negedge clk);
            seen = int_vec[1];
            check_val("int_o[2]", 0, int_vec[2]);
        end
        assert (seen)
        else begin
            $display("timer 0 interrupt did not rise within 40 cycles");
            errors++;
        end
        axi_read(32'h2000, 0, rd_val, resp);
        check_val("s_rdata_o", 32'h4, rd_val);  // enable cleared by expiry
        axi_write(32'h200C, 32'h1, 0, resp);
        check_val("int_o[1]", 0, int_vec[1]);
        check_val("int_o[2]", 0, int_vec[2]);

        // unmapped window
        axi_write(32'h8000, $random(seed), 5, resp);
        check_val("s_bresp_o", 3, resp);
        axi_read(32'h8000, 5, rd_val, resp);
        check_val("s_rresp_o", 3, resp);
        check_val("s_rdata_o", 0, rd_val);
        check_val("gpio_out_o", {24'h0, wr_val[7:0]}, {24'h0, gpio_out});  // last gpio out write
        check_val("int_o", 0, int_vec);

        repeat (5) @(negedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : tb_peripheral_bus
